// ==== logic/dram_ctrl_settings.svh ====
`ifndef DRAM_CTRL_SETTINGS_SVH
`define DRAM_CTRL_SETTINGS_SVH

// host link command word
`define DC_CMD_W 32
`define DC_OP_W 15
`define DC_ARG_W 17
`define DC_HALF_W 16

// memory user interface
`define DC_DATA_W 256
`define DC_ADDR_W 29
`define DC_BEAT_STEP 8
`define DC_CNT_W 32

`endif

// ==== logic/dram_ctrl_pkg.sv ====
`default_nettype none
`include "dram_ctrl_settings.svh"

package dram_ctrl_pkg;

    // host opcodes, low field of every command word
    typedef enum logic [`DC_OP_W-1:0] {
        OP_CALIB_DONE  = 3,
        OP_WIN_SET     = 4,
        OP_READBACK    = 5,
        OP_COUNT_QUERY = 6
    } cmd_op_t;

    typedef struct packed {
        logic [`DC_ARG_W-1:0] arg;
        cmd_op_t              op;
    } cmd_word_t;

    typedef enum logic [2:0] {
        APP_WRITE = 3'd0,
        APP_READ  = 3'd1
    } app_cmd_t;

    typedef enum logic [1:0] {WIN_BASE_LO, WIN_BASE_HI, WIN_LAST_LO, WIN_LAST_HI} win_state_t;

    typedef enum logic [1:0] {CHK_IDLE, CHK_READ, CHK_WAIT, CHK_REPORT} chk_state_t;

endpackage

`default_nettype wire

// ==== logic/app_if.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

interface app_if;

    // requester side, held until granted
    logic                    req;
    dram_ctrl_pkg::app_cmd_t cmd;
    logic [`DC_ADDR_W-1:0]   addr;
    logic [`DC_DATA_W-1:0]   wdata;

    // arbiter side
    logic                    grant;
    logic [`DC_DATA_W-1:0]   rdata;
    logic                    rdata_valid;

    modport requester (
        output req, cmd, addr, wdata,
        input  grant, rdata, rdata_valid
    );

    modport arbiter (
        input  req, cmd, addr, wdata,
        output grant, rdata, rdata_valid
    );

endinterface

`default_nettype wire

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module cmd_decoder (
    input  logic                     ui_clk,
    input  logic                     rst,
    input  dram_ctrl_pkg::cmd_word_t p2d_cmd_dout,
    input  logic                     p2d_cmd_empty,
    input  logic                     init_calib_complete,
    input  logic [`DC_CNT_W-1:0]     write_count,
    input  logic                     resp_grant,
    output logic                     p2d_cmd_rd_en,
    output logic [2*`DC_HALF_W-1:0]  win_base,
    output logic [2*`DC_HALF_W-1:0]  win_last,
    output logic                     count_clear,
    output logic                     resp_req,
    output dram_ctrl_pkg::cmd_word_t resp_word
);

    dram_ctrl_pkg::win_state_t phase;
    logic                      calib_sent;
    logic                      calib_pend;
    logic                      head_win;
    logic                      head_query;
    logic [`DC_HALF_W-1:0]     half;

    assign calib_pend = init_calib_complete && !calib_sent;
    assign head_win   = !p2d_cmd_empty && (p2d_cmd_dout.op == dram_ctrl_pkg::OP_WIN_SET);
    assign head_query = !p2d_cmd_empty && (p2d_cmd_dout.op == dram_ctrl_pkg::OP_COUNT_QUERY);
    assign half       = p2d_cmd_dout.arg[`DC_HALF_W-1:0];

    always_comb begin
        p2d_cmd_rd_en = 1'b0;
        resp_req      = 1'b0;
        resp_word     = '0;
        if (calib_pend) begin
            resp_req     = 1'b1;
            resp_word.op = dram_ctrl_pkg::OP_CALIB_DONE;
        end
        if (head_win && phase != dram_ctrl_pkg::WIN_LAST_HI) begin
            // first three setup words need no answer
            p2d_cmd_rd_en = 1'b1;
        end else if (head_win || head_query) begin
            // answered words wait behind the calibration notice
            if (!calib_pend) begin
                resp_req      = 1'b1;
                resp_word.op  = head_win ? dram_ctrl_pkg::OP_WIN_SET
                                         : dram_ctrl_pkg::OP_COUNT_QUERY;
                resp_word.arg = head_win ? '0 : write_count[`DC_ARG_W-1:0];
                p2d_cmd_rd_en = resp_grant;
            end
        end else if (!p2d_cmd_empty) begin
            // unknown opcode, drop it
            p2d_cmd_rd_en = 1'b1;
        end
    end

    assign count_clear = p2d_cmd_rd_en && head_win && (phase == dram_ctrl_pkg::WIN_BASE_LO);

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            phase      <= dram_ctrl_pkg::WIN_BASE_LO;
            calib_sent <= 1'b0;
        end else begin
            if (calib_pend && resp_grant) begin
                calib_sent <= 1'b1;
            end
            if (p2d_cmd_rd_en && head_win) begin
                case (phase)
                    dram_ctrl_pkg::WIN_BASE_LO: phase <= dram_ctrl_pkg::WIN_BASE_HI;
                    dram_ctrl_pkg::WIN_BASE_HI: phase <= dram_ctrl_pkg::WIN_LAST_LO;
                    dram_ctrl_pkg::WIN_LAST_LO: phase <= dram_ctrl_pkg::WIN_LAST_HI;
                    default:                    phase <= dram_ctrl_pkg::WIN_BASE_LO;
                endcase
            end
        end
    end

    // window halves, low half first
    always_ff @(posedge ui_clk) begin
        if (p2d_cmd_rd_en && head_win) begin
            case (phase)
                dram_ctrl_pkg::WIN_BASE_LO: win_base[0 +: `DC_HALF_W] <= half;
                dram_ctrl_pkg::WIN_BASE_HI: win_base[`DC_HALF_W +: `DC_HALF_W] <= half;
                dram_ctrl_pkg::WIN_LAST_LO: win_last[0 +: `DC_HALF_W] <= half;
                default:                    win_last[`DC_HALF_W +: `DC_HALF_W] <= half;
            endcase
        end
    end

    a_no_pop_when_empty: assert property (@(posedge ui_clk) disable iff (rst)
        !(p2d_cmd_rd_en && p2d_cmd_empty));

endmodule

`default_nettype wire

// ==== logic/stream_writer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module stream_writer (
    input  logic                    ui_clk,
    input  logic                    rst,
    input  logic [`DC_DATA_W-1:0]   p2d_data_dout,
    input  logic                    p2d_data_empty,
    input  logic [2*`DC_HALF_W-1:0] win_base,
    input  logic [2*`DC_HALF_W-1:0] win_last,
    input  logic                    count_clear,
    output logic                    p2d_data_rd_en,
    output logic [`DC_CNT_W-1:0]    write_count,
    output logic                    last_hit,
    output logic [`DC_ADDR_W-1:0]   hit_addr,
    app_if.requester                wr_bus
);

    logic [2*`DC_HALF_W-1:0] next_addr;
    logic                    at_last;

    // count is already in address units
    assign next_addr = win_base + write_count;
    assign at_last   = (win_last == {{(2*`DC_HALF_W-`DC_ADDR_W){1'b0}}, wr_bus.addr});

    assign wr_bus.req   = !p2d_data_empty;
    assign wr_bus.cmd   = dram_ctrl_pkg::APP_WRITE;
    assign wr_bus.addr  = next_addr[`DC_ADDR_W-1:0];
    assign wr_bus.wdata = p2d_data_dout;

    // pop in the grant cycle, the bus write follows one cycle later
    assign p2d_data_rd_en = wr_bus.grant;

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            write_count <= '0;
            last_hit    <= 1'b0;
        end else begin
            if (count_clear) begin
                write_count <= '0;
            end else if (wr_bus.grant) begin
                write_count <= write_count + `DC_BEAT_STEP;
            end
            last_hit <= wr_bus.grant && at_last;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (wr_bus.grant) begin
            hit_addr <= wr_bus.addr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/readback_checker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module readback_checker (
    input  logic                     ui_clk,
    input  logic                     rst,
    input  logic                     last_hit,
    input  logic [`DC_ADDR_W-1:0]    hit_addr,
    input  logic                     resp_grant,
    output logic                     resp_req,
    output dram_ctrl_pkg::cmd_word_t resp_word,
    app_if.requester                 rd_bus
);

    dram_ctrl_pkg::chk_state_t state;
    logic [`DC_ADDR_W-1:0]     check_addr;
    logic [`DC_HALF_W-1:0]     check_data;

    assign rd_bus.req   = (state == dram_ctrl_pkg::CHK_READ);
    assign rd_bus.cmd   = dram_ctrl_pkg::APP_READ;
    assign rd_bus.addr  = check_addr;
    assign rd_bus.wdata = '0;

    assign resp_req      = (state == dram_ctrl_pkg::CHK_REPORT);
    assign resp_word.op  = dram_ctrl_pkg::OP_READBACK;
    assign resp_word.arg = {{(`DC_ARG_W-`DC_HALF_W){1'b0}}, check_data};

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            state <= dram_ctrl_pkg::CHK_IDLE;
        end else begin
            case (state)
                dram_ctrl_pkg::CHK_IDLE:
                    if (last_hit) state <= dram_ctrl_pkg::CHK_READ;
                dram_ctrl_pkg::CHK_READ:
                    if (rd_bus.grant) state <= dram_ctrl_pkg::CHK_WAIT;
                dram_ctrl_pkg::CHK_WAIT:
                    if (rd_bus.rdata_valid) state <= dram_ctrl_pkg::CHK_REPORT;
                default:
                    if (resp_grant) state <= dram_ctrl_pkg::CHK_IDLE;
            endcase
        end
    end

    // only the low half of the beat is reported
    always_ff @(posedge ui_clk) begin
        if (state == dram_ctrl_pkg::CHK_IDLE && last_hit) begin
            check_addr <= hit_addr;
        end
        if (state == dram_ctrl_pkg::CHK_WAIT && rd_bus.rdata_valid) begin
            check_data <= rd_bus.rdata[`DC_HALF_W-1:0];
        end
    end

    // a second hit before the report would be lost
    a_hit_only_when_idle: assert property (@(posedge ui_clk) disable iff (rst)
        last_hit |-> state == dram_ctrl_pkg::CHK_IDLE);

endmodule

`default_nettype wire

// ==== logic/app_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module app_arbiter (
    input  logic                    ui_clk,
    input  logic                    rst,
    input  logic                    app_rdy,
    input  logic                    app_wdf_rdy,
    input  logic [`DC_DATA_W-1:0]   app_rd_data,
    input  logic                    app_rd_data_valid,
    output logic                    app_en,
    output dram_ctrl_pkg::app_cmd_t app_cmd,
    output logic [`DC_ADDR_W-1:0]   app_addr,
    output logic                    app_wdf_wren,
    output logic [`DC_DATA_W-1:0]   app_wdf_data,
    app_if.arbiter                  wr_bus,
    app_if.arbiter                  rd_bus
);

    logic                    wr_ok;
    logic                    rd_ok;
    logic                    any_grant;
    dram_ctrl_pkg::app_cmd_t sel_cmd;

    // writes also need room in the write data FIFO
    assign wr_ok = app_rdy && (wr_bus.cmd == dram_ctrl_pkg::APP_READ || app_wdf_rdy);
    assign rd_ok = app_rdy && (rd_bus.cmd == dram_ctrl_pkg::APP_READ || app_wdf_rdy);

    // readback wins
    assign rd_bus.grant = rd_bus.req && rd_ok;
    assign wr_bus.grant = wr_bus.req && wr_ok && !rd_bus.req;
    assign any_grant    = rd_bus.grant || wr_bus.grant;
    assign sel_cmd      = rd_bus.req ? rd_bus.cmd : wr_bus.cmd;

    assign rd_bus.rdata       = app_rd_data;
    assign rd_bus.rdata_valid = app_rd_data_valid;
    // writer issues no reads
    assign wr_bus.rdata       = app_rd_data;
    assign wr_bus.rdata_valid = 1'b0;

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            app_en       <= 1'b0;
            app_wdf_wren <= 1'b0;
        end else begin
            app_en       <= any_grant;
            app_wdf_wren <= any_grant && (sel_cmd == dram_ctrl_pkg::APP_WRITE);
        end
    end

    always_ff @(posedge ui_clk) begin
        app_cmd      <= sel_cmd;
        app_addr     <= rd_bus.req ? rd_bus.addr : wr_bus.addr;
        app_wdf_data <= rd_bus.req ? rd_bus.wdata : wr_bus.wdata;
    end

    a_one_grant: assert property (@(posedge ui_clk) disable iff (rst)
        !(wr_bus.grant && rd_bus.grant));

endmodule

`default_nettype wire

// ==== logic/resp_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module resp_arbiter (
    input  logic                     d2p_cmd_full,
    input  logic                     dec_req,
    input  dram_ctrl_pkg::cmd_word_t dec_word,
    input  logic                     chk_req,
    input  dram_ctrl_pkg::cmd_word_t chk_word,
    output logic                     dec_grant,
    output logic                     chk_grant,
    output logic                     d2p_cmd_wr_en,
    output logic [`DC_CMD_W-1:0]     d2p_cmd_din
);

    // checker report first, decoder waits behind it
    assign chk_grant = chk_req && !d2p_cmd_full;
    assign dec_grant = dec_req && !chk_req && !d2p_cmd_full;

    assign d2p_cmd_wr_en = chk_grant || dec_grant;
    assign d2p_cmd_din   = chk_req ? chk_word : dec_word;

    always_comb begin
        a_no_write_when_full: assert final (!(d2p_cmd_wr_en === 1'b1 && d2p_cmd_full === 1'b1));
    end

endmodule

`default_nettype wire

// ==== logic/dram_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module dram_ctrl_top (
    input  logic                    ui_clk,
    input  logic                    rst,
    output logic                    p2d_cmd_rd_en,
    input  logic [`DC_CMD_W-1:0]    p2d_cmd_dout,
    input  logic                    p2d_cmd_empty,
    output logic                    p2d_data_rd_en,
    input  logic [`DC_DATA_W-1:0]   p2d_data_dout,
    input  logic                    p2d_data_empty,
    output logic                    d2p_cmd_wr_en,
    output logic [`DC_CMD_W-1:0]    d2p_cmd_din,
    input  logic                    d2p_cmd_full,
    input  logic                    init_calib_complete,
    output logic                    app_en,
    output dram_ctrl_pkg::app_cmd_t app_cmd,
    output logic [`DC_ADDR_W-1:0]   app_addr,
    output logic                    app_wdf_wren,
    output logic [`DC_DATA_W-1:0]   app_wdf_data,
    input  logic                    app_rdy,
    input  logic                    app_wdf_rdy,
    input  logic [`DC_DATA_W-1:0]   app_rd_data,
    input  logic                    app_rd_data_valid
);

    logic [2*`DC_HALF_W-1:0]  win_base;
    logic [2*`DC_HALF_W-1:0]  win_last;
    logic                     count_clear;
    logic [`DC_CNT_W-1:0]     write_count;
    logic                     last_hit;
    logic [`DC_ADDR_W-1:0]    hit_addr;
    logic                     dec_req;
    logic                     dec_grant;
    dram_ctrl_pkg::cmd_word_t dec_word;
    logic                     chk_req;
    logic                     chk_grant;
    dram_ctrl_pkg::cmd_word_t chk_word;

    app_if wr_bus ();
    app_if rd_bus ();

    cmd_decoder u_cmd_decoder (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .p2d_cmd_dout        (p2d_cmd_dout),
        .p2d_cmd_empty       (p2d_cmd_empty),
        .init_calib_complete (init_calib_complete),
        .write_count         (write_count),
        .resp_grant          (dec_grant),
        .p2d_cmd_rd_en       (p2d_cmd_rd_en),
        .win_base            (win_base),
        .win_last            (win_last),
        .count_clear         (count_clear),
        .resp_req            (dec_req),
        .resp_word           (dec_word)
    );

    stream_writer u_stream_writer (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .p2d_data_dout  (p2d_data_dout),
        .p2d_data_empty (p2d_data_empty),
        .win_base       (win_base),
        .win_last       (win_last),
        .count_clear    (count_clear),
        .p2d_data_rd_en (p2d_data_rd_en),
        .write_count    (write_count),
        .last_hit       (last_hit),
        .hit_addr       (hit_addr),
        .wr_bus         (wr_bus.requester)
    );

    readback_checker u_readback_checker (
        .ui_clk     (ui_clk),
        .rst        (rst),
        .last_hit   (last_hit),
        .hit_addr   (hit_addr),
        .resp_grant (chk_grant),
        .resp_req   (chk_req),
        .resp_word  (chk_word),
        .rd_bus     (rd_bus.requester)
    );

    app_arbiter u_app_arbiter (
        .ui_clk            (ui_clk),
        .rst               (rst),
        .app_rdy           (app_rdy),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .app_en            (app_en),
        .app_cmd           (app_cmd),
        .app_addr          (app_addr),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_data      (app_wdf_data),
        .wr_bus            (wr_bus.arbiter),
        .rd_bus            (rd_bus.arbiter)
    );

    resp_arbiter u_resp_arbiter (
        .d2p_cmd_full  (d2p_cmd_full),
        .dec_req       (dec_req),
        .dec_word      (dec_word),
        .chk_req       (chk_req),
        .chk_word      (chk_word),
        .dec_grant     (dec_grant),
        .chk_grant     (chk_grant),
        .d2p_cmd_wr_en (d2p_cmd_wr_en),
        .d2p_cmd_din   (d2p_cmd_din)
    );

endmodule

`default_nettype wire

// ==== tb/app_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module app_mem_model (
    input  logic                    ui_clk,
    input  logic                    rst,
    input  logic                    app_en,
    input  dram_ctrl_pkg::app_cmd_t app_cmd,
    input  logic [`DC_ADDR_W-1:0]   app_addr,
    input  logic                    app_wdf_wren,
    input  logic [`DC_DATA_W-1:0]   app_wdf_data,
    output logic                    app_rdy,
    output logic                    app_wdf_rdy,
    output logic [`DC_DATA_W-1:0]   app_rd_data,
    output logic                    app_rd_data_valid
);

    logic [`DC_DATA_W-1:0] mem [logic [`DC_ADDR_W-1:0]];
    logic [`DC_DATA_W-1:0] rd_q [$];
    integer                seed;
    integer                wait_cnt;
    logic                  take_wr;
    logic                  take_rd;
    logic [`DC_ADDR_W-1:0] smp_addr;
    logic [`DC_DATA_W-1:0] smp_data;

    // locations never written return a pattern built from the address
    function automatic logic [`DC_DATA_W-1:0] read_word(input logic [`DC_ADDR_W-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end else begin
            return {8{3'b000, addr}};
        end
    endfunction

    initial begin
        seed              = 6278;
        wait_cnt          = 0;
        take_wr           = 1'b0;
        take_rd           = 1'b0;
        smp_addr          = '0;
        smp_data          = '0;
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
    end

    // bus outputs are registered, look at them mid-cycle
    always @(negedge ui_clk) begin
        take_wr  = app_en && app_wdf_wren && (app_cmd == dram_ctrl_pkg::APP_WRITE);
        take_rd  = app_en && (app_cmd == dram_ctrl_pkg::APP_READ);
        smp_addr = app_addr;
        smp_data = app_wdf_data;
    end

    always @(posedge ui_clk) begin
        #1;
        app_rd_data_valid = 1'b0;
        if (rst) begin
            rd_q.delete();
            app_rdy     = 1'b0;
            app_wdf_rdy = 1'b0;
        end else begin
            if (take_wr) begin
                mem[smp_addr] = smp_data;
            end
            if (take_rd) begin
                if (rd_q.size() == 0) begin
                    wait_cnt = $unsigned($random(seed)) % 6;
                end
                rd_q.push_back(read_word(smp_addr));
            end
            // 1 to 6 cycles from the read command to its data
            if (rd_q.size() > 0) begin
                if (wait_cnt == 0) begin
                    app_rd_data       = rd_q.pop_front();
                    app_rd_data_valid = 1'b1;
                    wait_cnt          = $unsigned($random(seed)) % 6;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
            app_rdy     = (($random(seed) & 3) != 0);
            app_wdf_rdy = (($random(seed) & 3) != 0);
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_dram_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dram_ctrl_settings.svh"

module tb_dram_ctrl;

    // a window takes about 60 cycles, so the limit leaves a wide margin
    localparam integer MAX_CYCLES  = 20000;
    localparam integer NUM_WINDOWS = 8;

    logic                    ui_clk = 1'b0;
    logic                    rst;
    logic                    p2d_cmd_rd_en;
    logic [`DC_CMD_W-1:0]    p2d_cmd_dout;
    logic                    p2d_cmd_empty;
    logic                    p2d_data_rd_en;
    logic [`DC_DATA_W-1:0]   p2d_data_dout;
    logic                    p2d_data_empty;
    logic                    d2p_cmd_wr_en;
    logic [`DC_CMD_W-1:0]    d2p_cmd_din;
    logic                    d2p_cmd_full;
    logic                    init_calib_complete;
    logic                    app_en;
    dram_ctrl_pkg::app_cmd_t app_cmd;
    logic [`DC_ADDR_W-1:0]   app_addr;
    logic                    app_wdf_wren;
    logic [`DC_DATA_W-1:0]   app_wdf_data;
    logic                    app_rdy;
    logic                    app_wdf_rdy;
    logic [`DC_DATA_W-1:0]   app_rd_data;
    logic                    app_rd_data_valid;

    // host FIFOs and the predicted traffic
    logic [`DC_CMD_W-1:0]    cmd_q [$];
    logic [`DC_DATA_W-1:0]   data_q [$];
    logic [`DC_CMD_W-1:0]    exp_dec [$];
    logic [`DC_CMD_W-1:0]    exp_rb [$];
    logic [`DC_ADDR_W-1:0]   exp_wr_addr [$];
    logic [`DC_DATA_W-1:0]   exp_wr_data [$];
    logic [`DC_ADDR_W-1:0]   exp_rd_addr [$];
    integer                  seed;
    integer                  cycles;
    logic                    pop_cmd;
    logic                    pop_data;

    dram_ctrl_top UUT (.*);

    app_mem_model u_mem (.*);

    initial begin
        forever #50 ui_clk = ~ui_clk;
    end

    function automatic logic [`DC_CMD_W-1:0] make_word(input logic [`DC_OP_W-1:0] op,
                                                       input logic [`DC_ARG_W-1:0] arg);
        return {arg, op};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [`DC_DATA_W-1:0] got,
                             input logic [`DC_DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t ns: %s is %0h, expected %0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic observe();
        pop_cmd  = p2d_cmd_rd_en;
        pop_data = p2d_data_rd_en;
        if (pop_cmd && cmd_q.size() == 0) begin
            stop_run("command FIFO popped while empty");
        end
        if (pop_data && data_q.size() == 0) begin
            stop_run("data FIFO popped while empty");
        end
        if (d2p_cmd_wr_en) begin
            check_val("d2p_cmd_full", d2p_cmd_full, 1'b0);
            if (d2p_cmd_din[`DC_OP_W-1:0] == dram_ctrl_pkg::OP_READBACK) begin
                if (exp_rb.size() == 0) begin
                    stop_run("readback response without a last-address write");
                end else begin
                    check_val("d2p_cmd_din", d2p_cmd_din, exp_rb.pop_front());
                end
            end else if (exp_dec.size() == 0) begin
                stop_run("response written while none was pending");
            end else begin
                check_val("d2p_cmd_din", d2p_cmd_din, exp_dec.pop_front());
            end
        end
        if (app_en && app_cmd == dram_ctrl_pkg::APP_WRITE) begin
            check_val("app_wdf_wren", app_wdf_wren, 1'b1);
            if (exp_wr_addr.size() == 0) begin
                stop_run("memory write with no beat pending");
            end else begin
                check_val("app_addr", app_addr, exp_wr_addr.pop_front());
                check_val("app_wdf_data", app_wdf_data, exp_wr_data.pop_front());
            end
        end else if (app_en) begin
            check_val("app_wdf_wren", app_wdf_wren, 1'b0);
            if (exp_rd_addr.size() == 0) begin
                stop_run("memory read without a last-address write");
            end else begin
                check_val("app_addr", app_addr, exp_rd_addr.pop_front());
            end
        end else begin
            check_val("app_wdf_wren", app_wdf_wren, 1'b0);
        end
    endtask

    // present inputs, watch outputs mid-cycle, retire pops after the edge
    task automatic step();
        p2d_cmd_empty  = (cmd_q.size() == 0);
        p2d_cmd_dout   = p2d_cmd_empty ? '0 : cmd_q[0];
        p2d_data_empty = (data_q.size() == 0);
        p2d_data_dout  = p2d_data_empty ? '0 : data_q[0];
        d2p_cmd_full   = rst ? 1'b0 : (($random(seed) & 3) == 0);
        @(negedge ui_clk);
        observe();
        @(posedge ui_clk);
        #1;
        if (pop_cmd) begin
            cmd_q.delete(0);
        end
        if (pop_data) begin
            data_q.delete(0);
        end
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run("timeout: responses or FIFO pops never arrived");
        end
    endtask

    task automatic run_window();
        logic [31:0]           base;
        logic [31:0]           last;
        logic [31:0]           addr;
        logic [`DC_DATA_W-1:0] beat;
        integer                nbeats;
        integer                hit_idx;
        integer                i;
        logic                  miss;
        nbeats  = 4 + $unsigned($random(seed)) % 9;
        hit_idx = $unsigned($random(seed)) % nbeats;
        miss    = (($random(seed) & 1) != 0);
        base    = $random(seed) & 32'h0fff_fff8;
        // a miss window puts its last address past the final beat
        last    = base + 8 * (miss ? nbeats + hit_idx : hit_idx);
        if (($random(seed) & 1) != 0) begin
            cmd_q.push_back(make_word(15'd7, {1'b0, base[31:16]}));
        end
        cmd_q.push_back(make_word(dram_ctrl_pkg::OP_WIN_SET, {1'b0, base[15:0]}));
        cmd_q.push_back(make_word(dram_ctrl_pkg::OP_WIN_SET, {1'b0, base[31:16]}));
        cmd_q.push_back(make_word(dram_ctrl_pkg::OP_WIN_SET, {1'b0, last[15:0]}));
        cmd_q.push_back(make_word(dram_ctrl_pkg::OP_WIN_SET, {1'b0, last[31:16]}));
        exp_dec.push_back(make_word(dram_ctrl_pkg::OP_WIN_SET, '0));
        // early setup words go out before calibration, the ack then waits behind the notice
        if (!init_calib_complete) begin
            repeat (3) step();
            init_calib_complete = 1'b1;
        end
        while (cmd_q.size() > 0) step();
        for (i = 0; i < nbeats; i = i + 1) begin
            beat = {$random(seed), $random(seed), $random(seed), $random(seed),
                    $random(seed), $random(seed), $random(seed), $random(seed)};
            addr = base + 8 * i;
            data_q.push_back(beat);
            exp_wr_addr.push_back(addr[`DC_ADDR_W-1:0]);
            exp_wr_data.push_back(beat);
            if (!miss && i == hit_idx) begin
                exp_rd_addr.push_back(addr[`DC_ADDR_W-1:0]);
                exp_rb.push_back(make_word(dram_ctrl_pkg::OP_READBACK, {1'b0, beat[15:0]}));
            end
        end
        while (data_q.size() > 0) step();
        if (($random(seed) & 1) != 0) begin
            // count is in address units
            addr = 8 * nbeats;
            cmd_q.push_back(make_word(dram_ctrl_pkg::OP_COUNT_QUERY, '0));
            exp_dec.push_back(make_word(dram_ctrl_pkg::OP_COUNT_QUERY, addr[`DC_ARG_W-1:0]));
        end
        while (cmd_q.size() + exp_dec.size() + exp_rb.size() + exp_wr_addr.size()
               + exp_rd_addr.size() > 0) step();
    endtask

    initial begin
        seed                = 6278;
        cycles              = 0;
        pop_cmd             = 1'b0;
        pop_data            = 1'b0;
        rst                 = 1'b1;
        init_calib_complete = 1'b0;
        p2d_cmd_dout        = '0;
        p2d_cmd_empty       = 1'b1;
        p2d_data_dout       = '0;
        p2d_data_empty      = 1'b1;
        d2p_cmd_full        = 1'b0;
        exp_dec.push_back(make_word(dram_ctrl_pkg::OP_CALIB_DONE, '0));
        repeat (3) step();
        rst = 1'b0;
        repeat (NUM_WINDOWS) run_window();
        // idle tail to catch stray responses
        repeat (20) step();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/dram_ctrl_pkg.sv
logic/app_if.sv
logic/cmd_decoder.sv
logic/stream_writer.sv
logic/readback_checker.sv
logic/app_arbiter.sv
logic/resp_arbiter.sv
logic/dram_ctrl_top.sv
tb/app_mem_model.sv
tb/tb_dram_ctrl.sv
